// File: src/stage1Pkg.sv
package stage1Pkg;

	////////////////////////////////////////////////////////////
	// Instruction format
	////////////////////////////////////////////////////////////

	localparam int InstrWidth = 8;
	localparam int OpWidth = 5;
	localparam int ModeWidth = 3;

	localparam logic [OpWidth-1:0] OpAdd = 5'b00000;
	localparam logic [OpWidth-1:0] OpSub = 5'b00001;
	localparam logic [OpWidth-1:0] OpOr = 5'b00011;
	localparam logic [OpWidth-1:0] OpAnd = 5'b00100;
	localparam logic [OpWidth-1:0] OpShft = 5'b00101;
	localparam logic [OpWidth-1:0] OpLoad = 5'b01010;
	localparam logic [OpWidth-1:0] OpStor = 5'b01011;
	localparam logic [OpWidth-1:0] OpNop = 5'b01111;

	localparam logic [ModeWidth-1:0] ModeDir = 3'd0;
	localparam logic [ModeWidth-1:0] ModeInd = 3'd1;
	localparam logic [ModeWidth-1:0] ModeImm = 3'd2;

	// One byte in memory-reference or shift layout
	typedef union packed {
		struct packed {
			logic [OpWidth-1:0] opcode;
			logic [ModeWidth-1:0] mode;
		} mem;
		struct packed {
			logic [OpWidth-1:0] opcode;
			logic unused;          // Must be 0
			logic right;           // 1 shifts right
			logic fill;            // Bit shifted in
		} shift;
	} instrWord;

	////////////////////////////////////////////////////////////
	// Decoded fields
	////////////////////////////////////////////////////////////

	localparam int ClassWidth = 2;

	localparam logic [ClassWidth-1:0] ClassAlu = 2'd0;
	localparam logic [ClassWidth-1:0] ClassStore = 2'd1;
	localparam logic [ClassWidth-1:0] ClassShift = 2'd2;
	localparam logic [ClassWidth-1:0] ClassNone = 2'd3;

	localparam int AluFuncWidth = 3;

	localparam logic [AluFuncWidth-1:0] FnAdd = 3'd0;
	localparam logic [AluFuncWidth-1:0] FnSub = 3'd1;
	localparam logic [AluFuncWidth-1:0] FnOr = 3'd2;
	localparam logic [AluFuncWidth-1:0] FnAnd = 3'd3;
	localparam logic [AluFuncWidth-1:0] FnPass = 3'd4;
	localparam logic [AluFuncWidth-1:0] FnShl = 3'd5;
	localparam logic [AluFuncWidth-1:0] FnShr = 3'd6;

	////////////////////////////////////////////////////////////
	// Sequencer states and control word
	////////////////////////////////////////////////////////////

	localparam int StateWidth = 4;

	localparam logic [StateWidth-1:0] StIdle = 4'd0;
	localparam logic [StateWidth-1:0] StAccept = 4'd1;
	localparam logic [StateWidth-1:0] StMarFromIr = 4'd2;
	localparam logic [StateWidth-1:0] StPtrWait = 4'd3;
	localparam logic [StateWidth-1:0] StMarFromMdr = 4'd4;
	localparam logic [StateWidth-1:0] StOperandWait = 4'd5;
	localparam logic [StateWidth-1:0] StExecute = 4'd6;
	localparam logic [StateWidth-1:0] StStoreWrite = 4'd7;
	localparam logic [StateWidth-1:0] StShift = 4'd8;

	localparam int CtrlWidth = 10;

	localparam int CtrlMarFromIr = 0;
	localparam int CtrlMarFromMdr = 1;
	localparam int CtrlMemRead = 2;
	localparam int CtrlMemWrite = 3;
	localparam int CtrlAccLoad = 4;
	localparam int CtrlAluSrcImm = 5;
	localparam int CtrlAluFuncLsb = 6;     // Bits 8:6
	localparam int CtrlShiftFill = 9;

	localparam int ShiftWidth = 3;

	// Cache wait
	localparam int MissCntWidth = 4;
	localparam logic [MissCntWidth-1:0] MissLimit = 4'd8;    // Misses before giving up

endpackage

// File: src/opDecoder.sv
`timescale 1ns/1ps

module opDecoder (
	input  logic [stage1Pkg::InstrWidth-1:0]   instr,
	output logic [stage1Pkg::ClassWidth-1:0]   opClass,
	output logic [stage1Pkg::ModeWidth-1:0]    addrMode,
	output logic [stage1Pkg::AluFuncWidth-1:0] aluFunc,
	output logic                               shiftRight,
	output logic                               shiftFill,
	output logic                               legal
);

	stage1Pkg::instrWord word;
	logic memMode;     // Direct or indirect
	logic anyMode;     // Memory or immediate

	assign word = instr;
	assign addrMode = word.mem.mode;
	assign shiftRight = word.shift.right;
	assign shiftFill = word.shift.fill;

	assign memMode = (word.mem.mode == stage1Pkg::ModeDir) ||
		(word.mem.mode == stage1Pkg::ModeInd);
	assign anyMode = memMode || (word.mem.mode == stage1Pkg::ModeImm);

	always_comb begin
		opClass = stage1Pkg::ClassNone;
		aluFunc = stage1Pkg::FnPass;
		legal = 1'b0;
		case (word.mem.opcode)
			stage1Pkg::OpAdd, stage1Pkg::OpSub, stage1Pkg::OpOr, stage1Pkg::OpAnd,
			stage1Pkg::OpLoad: begin
				opClass = stage1Pkg::ClassAlu;
				legal = anyMode;
				case (word.mem.opcode)
					stage1Pkg::OpAdd: aluFunc = stage1Pkg::FnAdd;
					stage1Pkg::OpSub: aluFunc = stage1Pkg::FnSub;
					stage1Pkg::OpOr: aluFunc = stage1Pkg::FnOr;
					stage1Pkg::OpAnd: aluFunc = stage1Pkg::FnAnd;
					default: aluFunc = stage1Pkg::FnPass;     // LOAD
				endcase
			end
			stage1Pkg::OpStor: begin
				opClass = stage1Pkg::ClassStore;
				legal = memMode;     // No immediate store
			end
			stage1Pkg::OpShft: begin
				opClass = stage1Pkg::ClassShift;
				legal = !word.shift.unused;
				aluFunc = shiftRight ? stage1Pkg::FnShr : stage1Pkg::FnShl;
			end
			stage1Pkg::OpNop: begin
				legal = 1'b1;
			end
			default: ;     // Dropped or unknown opcode
		endcase
	end

endmodule

// File: src/memWaitTimer.sv
`timescale 1ns/1ps

module memWaitTimer (
	input  logic clk,
	input  logic arstN,
	input  logic waitActive,
	input  logic cacheHit,
	output logic waitDone
);

	logic                               settled;     // Past the settle cycle
	logic [stage1Pkg::MissCntWidth-1:0] missCnt;
	logic                               limitHit;

	assign limitHit = (missCnt == stage1Pkg::MissLimit);

	// Hit is only looked at once the access has settled
	assign waitDone = waitActive && settled && (cacheHit || limitHit);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			settled <= 1'b0;
			missCnt <= '0;
		end else if (!waitActive || waitDone) begin
			settled <= 1'b0;
			missCnt <= '0;
		end else if (!settled) begin
			settled <= 1'b1;     // Cycle 1 done
		end else begin
			missCnt <= missCnt + 1'b1;     // Another miss
		end
	end

endmodule

// File: src/stage1Sequencer.sv
`timescale 1ns/1ps

module stage1Sequencer (
	input  logic                             clk,
	input  logic                             arstN,
	input  logic                             stg0State,
	input  logic [stage1Pkg::ClassWidth-1:0] opClass,
	input  logic [stage1Pkg::ModeWidth-1:0]  addrMode,
	input  logic                             legal,
	input  logic                             waitDone,
	output logic [stage1Pkg::StateWidth-1:0] state,
	output logic                             waitActive
);

	logic [stage1Pkg::StateWidth-1:0] nextState;
	logic                             isStore;
	logic                             isIndirect;

	assign isStore = (opClass == stage1Pkg::ClassStore);
	assign isIndirect = (addrMode == stage1Pkg::ModeInd);

	assign waitActive = (state == stage1Pkg::StPtrWait) ||
		(state == stage1Pkg::StOperandWait);

	////////////////////////////////////////////////////////////
	// State register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stage1Pkg::StIdle;
		end else begin
			state <= nextState;
		end
	end

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			stage1Pkg::StIdle: begin
				if (stg0State) begin
					nextState = stage1Pkg::StAccept;
				end
			end

			stage1Pkg::StAccept: begin
				// Hold here while stage 0 has nothing valid
				if (stg0State) begin
					if (!legal || (opClass == stage1Pkg::ClassNone)) begin
						nextState = stage1Pkg::StIdle;     // NOP or illegal retires
					end else if (opClass == stage1Pkg::ClassShift) begin
						nextState = stage1Pkg::StShift;
					end else if (addrMode == stage1Pkg::ModeImm) begin
						nextState = stage1Pkg::StExecute;
					end else begin
						nextState = stage1Pkg::StMarFromIr;
					end
				end
			end

			stage1Pkg::StMarFromIr: begin
				if (isIndirect) begin
					nextState = stage1Pkg::StPtrWait;
				end else if (isStore) begin
					nextState = stage1Pkg::StStoreWrite;
				end else begin
					nextState = stage1Pkg::StOperandWait;
				end
			end

			stage1Pkg::StPtrWait: begin
				if (waitDone) begin
					nextState = stage1Pkg::StMarFromMdr;
				end
			end

			stage1Pkg::StMarFromMdr: begin
				if (isStore) begin
					nextState = stage1Pkg::StStoreWrite;
				end else begin
					nextState = stage1Pkg::StOperandWait;
				end
			end

			stage1Pkg::StOperandWait: begin
				if (waitDone) begin
					nextState = stage1Pkg::StExecute;
				end
			end

			stage1Pkg::StExecute, stage1Pkg::StStoreWrite, stage1Pkg::StShift: begin
				nextState = stage1Pkg::StIdle;     // Single cycle
			end

			default: begin
				nextState = stage1Pkg::StIdle;
			end
		endcase
	end

endmodule

// File: src/ctrlEncoder.sv
`timescale 1ns/1ps

module ctrlEncoder (
	input  logic [stage1Pkg::StateWidth-1:0]   state,
	input  logic [stage1Pkg::AluFuncWidth-1:0] aluFunc,
	input  logic [stage1Pkg::ModeWidth-1:0]    addrMode,
	input  logic                               shiftFill,
	input  logic [stage1Pkg::InstrWidth-1:0]   irData,
	output logic [stage1Pkg::CtrlWidth-1:0]    ctrlWord,
	output logic [stage1Pkg::ShiftWidth-1:0]   numShift,
	output logic                               stg1State
);

	assign stg1State = (state == stage1Pkg::StAccept);     // Tells stage 0 it was taken

	////////////////////////////////////////////////////////////
	// Moore outputs
	////////////////////////////////////////////////////////////

	always_comb begin
		ctrlWord = '0;
		numShift = '0;
		case (state)
			stage1Pkg::StMarFromIr: begin
				ctrlWord[stage1Pkg::CtrlMarFromIr] = 1'b1;
			end

			stage1Pkg::StMarFromMdr: begin
				ctrlWord[stage1Pkg::CtrlMarFromMdr] = 1'b1;     // Pointer becomes address
			end

			stage1Pkg::StPtrWait, stage1Pkg::StOperandWait: begin
				ctrlWord[stage1Pkg::CtrlMemRead] = 1'b1;
			end

			stage1Pkg::StStoreWrite: begin
				ctrlWord[stage1Pkg::CtrlMemWrite] = 1'b1;
			end

			stage1Pkg::StExecute: begin
				ctrlWord[stage1Pkg::CtrlAccLoad] = 1'b1;
				ctrlWord[stage1Pkg::CtrlAluFuncLsb +: stage1Pkg::AluFuncWidth] = aluFunc;
				// Operand from the instruction path, not memory
				if (addrMode == stage1Pkg::ModeImm) begin
					ctrlWord[stage1Pkg::CtrlAluSrcImm] = 1'b1;
				end
			end

			stage1Pkg::StShift: begin
				ctrlWord[stage1Pkg::CtrlAccLoad] = 1'b1;
				ctrlWord[stage1Pkg::CtrlAluFuncLsb +: stage1Pkg::AluFuncWidth] = aluFunc;
				ctrlWord[stage1Pkg::CtrlShiftFill] = shiftFill;
				numShift = irData[stage1Pkg::ShiftWidth-1:0];     // Count from data reg
			end

			default: ;     // Idle and accept drive nothing
		endcase
	end

endmodule

// File: src/stage1Ctrl.sv
`timescale 1ns/1ps

module stage1Ctrl (
	input  logic                             clk,
	input  logic                             arstN,
	input  logic [stage1Pkg::InstrWidth-1:0] instr,
	input  logic                             stg0State,
	input  logic                             cacheHit,
	input  logic [stage1Pkg::InstrWidth-1:0] irData,
	output logic [stage1Pkg::CtrlWidth-1:0]  ctrlWord,
	output logic [stage1Pkg::ShiftWidth-1:0] numShift,
	output logic                             stg1State
);

	logic [stage1Pkg::ClassWidth-1:0]   opClass;
	logic [stage1Pkg::ModeWidth-1:0]    addrMode;
	logic [stage1Pkg::AluFuncWidth-1:0] aluFunc;
	logic                               shiftFill;
	logic                               legal;
	logic [stage1Pkg::StateWidth-1:0]   state;
	logic                               waitActive;
	logic                               waitDone;

	opDecoder uDecoder (
		.instr      (instr),
		.opClass    (opClass),
		.addrMode   (addrMode),
		.aluFunc    (aluFunc),
		.shiftRight (),          // Folded into aluFunc
		.shiftFill  (shiftFill),
		.legal      (legal)
	);

	memWaitTimer uTimer (
		.clk        (clk),
		.arstN      (arstN),
		.waitActive (waitActive),
		.cacheHit   (cacheHit),
		.waitDone   (waitDone)
	);

	stage1Sequencer uSequencer (
		.clk        (clk),
		.arstN      (arstN),
		.stg0State  (stg0State),
		.opClass    (opClass),
		.addrMode   (addrMode),
		.legal      (legal),
		.waitDone   (waitDone),
		.state      (state),
		.waitActive (waitActive)
	);

	ctrlEncoder uEncoder (
		.state     (state),
		.aluFunc   (aluFunc),
		.addrMode  (addrMode),
		.shiftFill (shiftFill),
		.irData    (irData),
		.ctrlWord  (ctrlWord),
		.numShift  (numShift),
		.stg1State (stg1State)
	);

endmodule

// File: verification/stage1CtrlTb.sv
`timescale 1ns/1ps

module stage1CtrlTb;

	localparam int CycleLimit = 2000;     // Several times the test length
	localparam logic [stage1Pkg::OpWidth-1:0] DroppedOp = 5'b00010;     // Dropped like MULDIV

	logic                             clk;
	logic                             arstN;
	logic [stage1Pkg::InstrWidth-1:0] instr;
	logic                             stg0State;
	logic                             cacheHit;
	logic [stage1Pkg::InstrWidth-1:0] irData;
	logic [stage1Pkg::CtrlWidth-1:0]  ctrlWord;
	logic [stage1Pkg::ShiftWidth-1:0] numShift;
	logic                             stg1State;

	int     cycleCount = 0;
	integer seed = 32'h8205_b71f;

	stage1Ctrl dut (
		.clk       (clk),
		.arstN     (arstN),
		.instr     (instr),
		.stg0State (stg0State),
		.cacheHit  (cacheHit),
		.irData    (irData),
		.ctrlWord  (ctrlWord),
		.numShift  (numShift),
		.stg1State (stg1State)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("TB FAILED");
			$fatal(1, "Run aborted");
		end
	end

	////////////////////////////////////////////////////////////
	// Expected values and checks
	////////////////////////////////////////////////////////////

	function automatic logic [stage1Pkg::CtrlWidth-1:0] oneStrobe(input int pos);
		logic [stage1Pkg::CtrlWidth-1:0] w;
		w = '0;
		w[pos] = 1'b1;
		return w;
	endfunction

	// Accumulator load with function code
	function automatic logic [stage1Pkg::CtrlWidth-1:0] accWord(
		input logic [stage1Pkg::AluFuncWidth-1:0] fn, input logic imm, input logic fill);
		logic [stage1Pkg::CtrlWidth-1:0] w;
		w = '0;
		w[stage1Pkg::CtrlAccLoad] = 1'b1;
		w[stage1Pkg::CtrlAluSrcImm] = imm;
		w[stage1Pkg::CtrlAluFuncLsb +: stage1Pkg::AluFuncWidth] = fn;
		w[stage1Pkg::CtrlShiftFill] = fill;
		return w;
	endfunction

	function automatic logic [stage1Pkg::InstrWidth-1:0] memInstr(
		input logic [stage1Pkg::OpWidth-1:0] op, input logic [stage1Pkg::ModeWidth-1:0] mode);
		return {op, mode};
	endfunction

	function automatic logic [stage1Pkg::InstrWidth-1:0] shiftInstr(input logic right,
		input logic fill);
		return {stage1Pkg::OpShft, 1'b0, right, fill};     // Unused bit kept 0
	endfunction

	task automatic checkEq(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("TB FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic compareOutputs(input logic [stage1Pkg::CtrlWidth-1:0] expCtrl,
		input logic [stage1Pkg::ShiftWidth-1:0] expShift, input logic expAccept);
		checkEq("ctrlWord", 32'(ctrlWord), 32'(expCtrl));
		checkEq("numShift", 32'(numShift), 32'(expShift));
		checkEq("stg1State", 32'(stg1State), 32'(expAccept));
	endtask

	task automatic idleNext();
		@(negedge clk);
		compareOutputs('0, '0, 1'b0);
	endtask

	// Returns at the negedge of the cycle after the branch
	task automatic acceptInstr(input logic [stage1Pkg::InstrWidth-1:0] code);
		@(negedge clk);
		instr = code;
		stg0State = 1'b1;
		@(negedge clk);
		compareOutputs('0, '0, 1'b1);
		@(negedge clk);
		stg0State = 1'b0;
	endtask

	// Counts read cycles and drives the hit in cycle hitAt
	task automatic waitRead(input int hitAt, input bit settleHit, output int cycles);
		cycles = 0;
		while (ctrlWord[stage1Pkg::CtrlMemRead]) begin
			cycles++;
			compareOutputs(oneStrobe(stage1Pkg::CtrlMemRead), '0, 1'b0);
			cacheHit = (cycles == hitAt) || (settleHit && (cycles == 1));
			@(negedge clk);
		end
		cacheHit = 1'b0;
	endtask

	task automatic runDirect(input logic [stage1Pkg::OpWidth-1:0] op,
		input logic [stage1Pkg::AluFuncWidth-1:0] fn, input int hitAt, input bit settleHit,
		input int expCycles);
		int cycles;
		acceptInstr(memInstr(op, stage1Pkg::ModeDir));
		compareOutputs(oneStrobe(stage1Pkg::CtrlMarFromIr), '0, 1'b0);
		@(negedge clk);
		waitRead(hitAt, settleHit, cycles);
		checkEq("readCycles", cycles, expCycles);
		compareOutputs(accWord(fn, 1'b0, 1'b0), '0, 1'b0);
		idleNext();
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic resetAndAccept();
		repeat (3) begin
			@(negedge clk);
			compareOutputs('0, '0, 1'b0);
		end
		arstN = 1'b1;
		repeat (4) begin
			@(negedge clk);
			compareOutputs('0, '0, 1'b0);
		end
		instr = memInstr(stage1Pkg::OpNop, stage1Pkg::ModeDir);
		stg0State = 1'b1;
		@(negedge clk);
		compareOutputs('0, '0, 1'b1);
		stg0State = 1'b0;     // Back-pressure from stage 0
		repeat (3) begin
			@(negedge clk);
			compareOutputs('0, '0, 1'b1);
		end
		stg0State = 1'b1;
		@(negedge clk);
		compareOutputs('0, '0, 1'b0);     // NOP retired
		stg0State = 1'b0;
	endtask

	task automatic immediateOps();
		logic [stage1Pkg::OpWidth-1:0] ops [5];
		logic [stage1Pkg::AluFuncWidth-1:0] fns [5];
		ops = '{stage1Pkg::OpAdd, stage1Pkg::OpSub, stage1Pkg::OpOr, stage1Pkg::OpAnd,
			stage1Pkg::OpLoad};
		fns = '{stage1Pkg::FnAdd, stage1Pkg::FnSub, stage1Pkg::FnOr, stage1Pkg::FnAnd,
			stage1Pkg::FnPass};
		for (int i = 0; i < 5; i++) begin
			acceptInstr(memInstr(ops[i], stage1Pkg::ModeImm));
			compareOutputs(accWord(fns[i], 1'b1, 1'b0), '0, 1'b0);
			idleNext();
		end
	endtask

	task automatic directLoad();
		int hitAt;
		for (int k = 0; k < 4; k++) begin
			hitAt = 2 + int'($unsigned($random(seed)) % 8);
			runDirect(stage1Pkg::OpLoad, stage1Pkg::FnPass, hitAt, 1'b0, hitAt);
		end
		runDirect(stage1Pkg::OpLoad, stage1Pkg::FnPass, 6, 1'b1, 6);
		// Hit only while settling
		runDirect(stage1Pkg::OpLoad, stage1Pkg::FnPass, 0, 1'b1,
			int'(stage1Pkg::MissLimit) + 2);
	endtask

	task automatic missTimeout();
		runDirect(stage1Pkg::OpAdd, stage1Pkg::FnAdd, 0, 1'b0, int'(stage1Pkg::MissLimit) + 2);
	endtask

	task automatic indirectAndStore();
		int cycles;
		acceptInstr(memInstr(stage1Pkg::OpAnd, stage1Pkg::ModeInd));
		compareOutputs(oneStrobe(stage1Pkg::CtrlMarFromIr), '0, 1'b0);
		@(negedge clk);
		waitRead(3, 1'b0, cycles);     // Pointer read
		checkEq("ptrWaitCycles", cycles, 3);
		compareOutputs(oneStrobe(stage1Pkg::CtrlMarFromMdr), '0, 1'b0);
		@(negedge clk);
		waitRead(7, 1'b0, cycles);     // Operand read
		checkEq("operandWaitCycles", cycles, 7);
		compareOutputs(accWord(stage1Pkg::FnAnd, 1'b0, 1'b0), '0, 1'b0);
		idleNext();

		acceptInstr(memInstr(stage1Pkg::OpStor, stage1Pkg::ModeDir));
		compareOutputs(oneStrobe(stage1Pkg::CtrlMarFromIr), '0, 1'b0);
		@(negedge clk);
		compareOutputs(oneStrobe(stage1Pkg::CtrlMemWrite), '0, 1'b0);
		idleNext();

		acceptInstr(memInstr(stage1Pkg::OpStor, stage1Pkg::ModeInd));
		compareOutputs(oneStrobe(stage1Pkg::CtrlMarFromIr), '0, 1'b0);
		@(negedge clk);
		waitRead(2, 1'b0, cycles);
		checkEq("ptrWaitCycles", cycles, 2);
		compareOutputs(oneStrobe(stage1Pkg::CtrlMarFromMdr), '0, 1'b0);
		@(negedge clk);
		compareOutputs(oneStrobe(stage1Pkg::CtrlMemWrite), '0, 1'b0);
		idleNext();
	endtask

	task automatic shiftNopIllegal();
		logic [stage1Pkg::InstrWidth-1:0] bad [3];
		bad = '{memInstr(stage1Pkg::OpNop, stage1Pkg::ModeDir),
			memInstr(DroppedOp, stage1Pkg::ModeDir),
			memInstr(stage1Pkg::OpStor, stage1Pkg::ModeImm)};
		for (int v = 0; v < 4; v++) begin
			irData = 8'($random(seed));
			acceptInstr(shiftInstr(v[1], v[0]));
			compareOutputs(accWord(v[1] ? stage1Pkg::FnShr : stage1Pkg::FnShl, 1'b0, v[0]),
				irData[stage1Pkg::ShiftWidth-1:0], 1'b0);
			idleNext();
		end
		for (int i = 0; i < 3; i++) begin
			acceptInstr(bad[i]);
			compareOutputs('0, '0, 1'b0);     // Retired with no strobes
			idleNext();
		end
	endtask

	initial begin
		arstN = 1'b0;
		instr = '0;
		stg0State = 1'b0;
		cacheHit = 1'b0;
		irData = '0;
		resetAndAccept();
		immediateOps();
		directLoad();
		missTimeout();
		indirectAndStore();
		shiftNopIllegal();
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: stage1Ctrl.f
src/stage1Pkg.sv
src/opDecoder.sv
src/memWaitTimer.sv
src/stage1Sequencer.sv
src/ctrlEncoder.sv
src/stage1Ctrl.sv
verification/stage1CtrlTb.sv

// File: Makefile
TOP = stage1CtrlTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f stage1Ctrl.f

sim:
	verilator --binary --top-module $(TOP) -Mdir obj_dir -f stage1Ctrl.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
